// File: design/nocRouter_consts.svh
`default_nettype none

`ifndef NOCROUTER_CONSTS_SVH
`define NOCROUTER_CONSTS_SVH

// input ports on one output channel.
`define PORT_COUNT 5

// flit field widths.
`define LENGTH_WIDTH 12
`define PAYLOAD_WIDTH 32
`define KIND_WIDTH 3

`endif

`default_nettype wire

// File: design/nocPkg.sv
`include "nocRouter_consts.svh"
`default_nettype none

package nocPkg;

  // one-hot flit kind codes.
  typedef enum logic [`KIND_WIDTH-1:0] {
    kindHeader = 3'b001,
    kindBody   = 3'b010,
    kindTail   = 3'b100
  } flitKind;

  // input ports in priority order.
  typedef enum logic [2:0] {
    portLocal,
    portNorth,
    portEast,
    portWest,
    portSouth
  } portIndex;

  // length counts every flit of the packet, header included.
  typedef struct packed {
    flitKind                     kind;
    logic [`LENGTH_WIDTH-1:0]    length;
    logic [`PAYLOAD_WIDTH-1:0]   payload;
  } flit;

  // bit 0 is idle, bits 1 to 5 follow portIndex.
  typedef enum logic [`PORT_COUNT:0] {
    grantIdle  = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } grantState;

endpackage

`default_nettype wire

// File: design/flitLink.sv
`default_nettype none

// one four-phase flit channel.
interface flitLink;

  logic        req;
  logic        ack;
  nocPkg::flit flit;

  // flit must be stable while req is high.
  modport source (
    output req,
    output flit,
    input  ack
  );

  modport sink (
    input  req,
    input  flit,
    output ack
  );

  modport monitor (
    input req,
    input ack,
    input flit
  );

endinterface

`default_nettype wire

// File: design/flitCounter.sv
`include "nocRouter_consts.svh"
`default_nettype none

module flitCounter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     granted,
  input  logic                     transferDone,
  input  nocPkg::flitKind          kind,
  input  logic [`LENGTH_WIDTH-1:0] length,
  output logic                     packetDone
);

  logic [`LENGTH_WIDTH-1:0] storedLength;
  logic [`LENGTH_WIDTH-1:0] count;

  // count restarts once the port loses its grant.
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (!granted)
      count <= '0;
    else if (transferDone)
    begin
      if (kind == nocPkg::kindHeader)
        count <= `LENGTH_WIDTH'(1);
      else
        count <= count + `LENGTH_WIDTH'(1);
    end
  end

  // header carries the packet length.
  always_ff @(posedge clk)
  begin
    if (granted && transferDone && kind == nocPkg::kindHeader)
      storedLength <= length;
  end

  // zero count means no header seen yet.
  assign packetDone = (count != '0) && (count == storedLength);

endmodule

`default_nettype wire

// File: design/packetArbiter.sv
`include "nocRouter_consts.svh"
`default_nettype none

module packetArbiter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`PORT_COUNT-1:0]   requests,
  input  nocPkg::flitKind          kind,
  input  logic [`LENGTH_WIDTH-1:0] length,
  input  logic                     transferDone,
  input  logic                     linkIdle,
  output nocPkg::grantState        grant
);

  logic [`PORT_COUNT-1:0] packetDone;
  nocPkg::grantState      nextGrant;
  nocPkg::portIndex       owner;
  logic                   ownerValid;

  // first requester after the owner, owner itself last.
  function automatic nocPkg::grantState nextOwner(
    input logic [`PORT_COUNT-1:0] req,
    input nocPkg::portIndex       from
  );
    int   idx;
    int   step;
    logic found;
    nextOwner = nocPkg::grantIdle;
    found = 1'b0;
    for (step = 1; step <= `PORT_COUNT; step++)
    begin
      idx = (int'(from) + step) % `PORT_COUNT;
      if (!found && req[idx])
      begin
        nextOwner = nocPkg::grantState'((`PORT_COUNT + 1)'(1) << (idx + 1));
        found = 1'b1;
      end
    end
  endfunction

  // one length counter per port.
  for (genvar i = 0; i < `PORT_COUNT; i++)
  begin : gCounters
    flitCounter counter_i (
      .clk          (clk),
      .rst          (rst),
      .granted      (grant[i + 1]),
      .transferDone (transferDone),
      .kind         (kind),
      .length       (length),
      .packetDone   (packetDone[i])
    );
  end

  // decode the port that holds the grant.
  always_comb
  begin
    ownerValid = 1'b1;
    owner = nocPkg::portLocal;
    case (grant)
      nocPkg::grantLocal: owner = nocPkg::portLocal;
      nocPkg::grantNorth: owner = nocPkg::portNorth;
      nocPkg::grantEast:  owner = nocPkg::portEast;
      nocPkg::grantWest:  owner = nocPkg::portWest;
      nocPkg::grantSouth: owner = nocPkg::portSouth;
      default:            ownerValid = 1'b0;
    endcase
  end

  // grant stays locked until the whole packet has left the switch.
  always_comb
  begin
    if (!ownerValid)
      // scanning after south puts local first.
      nextGrant = nextOwner(requests, nocPkg::portSouth);
    else if (packetDone[owner] && linkIdle)
      nextGrant = nextOwner(requests, owner);
    else
      nextGrant = grant;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= nocPkg::grantIdle;
    else
      grant <= nextGrant;
  end

endmodule

`default_nettype wire

// File: design/flitSwitch.sv
`include "nocRouter_consts.svh"
`default_nettype none

module flitSwitch (
  input  logic                     clk,
  input  logic                     rst,
  flitLink.sink                    inLinks [`PORT_COUNT],
  flitLink.source                  outLink,
  input  nocPkg::grantState        grant,
  output logic [`PORT_COUNT-1:0]   requests,
  output nocPkg::flitKind          grantedKind,
  output logic [`LENGTH_WIDTH-1:0] grantedLength,
  output logic                     transferDone,
  output logic                     linkIdle
);

  localparam logic [1:0] phaseIdle    = 2'd0;
  localparam logic [1:0] phaseOffer   = 2'd1;
  localparam logic [1:0] phaseAcked   = 2'd2;
  localparam logic [1:0] phaseRelease = 2'd3;

  logic [1:0]             phase;
  nocPkg::flit            inFlits [`PORT_COUNT];
  nocPkg::flit            selectedFlit;
  nocPkg::flit            offerFlit;
  logic                   offerReq;
  logic [`PORT_COUNT-1:0] ackVec;
  logic [`PORT_COUNT-1:0] grantedPort;
  logic                   grantedReq;

  assign grantedPort = grant[`PORT_COUNT:1];

  for (genvar i = 0; i < `PORT_COUNT; i++)
  begin : gInputs
    assign requests[i] = inLinks[i].req;
    assign inFlits[i] = inLinks[i].flit;
    assign inLinks[i].ack = ackVec[i];
  end

  assign grantedReq = |(requests & grantedPort);

  // and-or mux on the one-hot grant.
  always_comb
  begin
    selectedFlit = '0;
    for (int i = 0; i < `PORT_COUNT; i++)
    begin
      if (grantedPort[i])
        selectedFlit = inFlits[i];
    end
  end

  // input handshake completes only after the output side has released.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase <= phaseIdle;
      offerReq <= 1'b0;
      ackVec <= '0;
    end
    else
    begin
      case (phase)
        phaseIdle:
          if (grantedReq)
          begin
            offerReq <= 1'b1;
            phase <= phaseOffer;
          end
        phaseOffer:
          if (outLink.ack)
          begin
            offerReq <= 1'b0;
            ackVec <= grantedPort;
            phase <= phaseAcked;
          end
        phaseAcked:
          phase <= phaseRelease;
        default:
          if (!grantedReq && !outLink.ack)
          begin
            ackVec <= '0;
            phase <= phaseIdle;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (phase == phaseIdle && grantedReq)
      offerFlit <= selectedFlit;
  end

  assign outLink.req = offerReq;
  assign outLink.flit = offerFlit;

  // counters see the flit that just crossed.
  assign grantedKind = offerFlit.kind;
  assign grantedLength = offerFlit.length;
  assign transferDone = (phase == phaseAcked);

  // also high on the cycle the release finishes, so grant and phase move together.
  assign linkIdle = !grantedReq &&
                    ((phase == phaseIdle) || (phase == phaseRelease && !outLink.ack));

endmodule

`default_nettype wire

// File: design/routerOutputPort.sv
`include "nocRouter_consts.svh"
`default_nettype none

module routerOutputPort (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`PORT_COUNT-1:0]    inReq,
  output logic [`PORT_COUNT-1:0]    inAck,
  input  logic [`KIND_WIDTH-1:0]    inKind [`PORT_COUNT],
  input  logic [`LENGTH_WIDTH-1:0]  inLength [`PORT_COUNT],
  input  logic [`PAYLOAD_WIDTH-1:0] inPayload [`PORT_COUNT],
  output logic                      outReq,
  input  logic                      outAck,
  output logic [`KIND_WIDTH-1:0]    outKind,
  output logic [`LENGTH_WIDTH-1:0]  outLength,
  output logic [`PAYLOAD_WIDTH-1:0] outPayload
);

  logic [`PORT_COUNT-1:0]   requests;
  nocPkg::grantState        grant;
  nocPkg::flitKind          grantedKind;
  logic [`LENGTH_WIDTH-1:0] grantedLength;
  logic                     transferDone;
  logic                     linkIdle;

  flitLink inLinks [`PORT_COUNT] ();
  flitLink outLink ();

  // plain input arrays onto the links.
  for (genvar i = 0; i < `PORT_COUNT; i++)
  begin : gInputs
    assign inLinks[i].req = inReq[i];
    assign inLinks[i].flit.kind = nocPkg::flitKind'(inKind[i]);
    assign inLinks[i].flit.length = inLength[i];
    assign inLinks[i].flit.payload = inPayload[i];
    assign inAck[i] = inLinks[i].ack;
  end

  assign outReq = outLink.req;
  assign outKind = outLink.flit.kind;
  assign outLength = outLink.flit.length;
  assign outPayload = outLink.flit.payload;
  assign outLink.ack = outAck;

  packetArbiter arbiter_i (
    .clk          (clk),
    .rst          (rst),
    .requests     (requests),
    .kind         (grantedKind),
    .length       (grantedLength),
    .transferDone (transferDone),
    .linkIdle     (linkIdle),
    .grant        (grant)
  );

  flitSwitch switch_i (
    .clk           (clk),
    .rst           (rst),
    .inLinks       (inLinks),
    .outLink       (outLink),
    .grant         (grant),
    .requests      (requests),
    .grantedKind   (grantedKind),
    .grantedLength (grantedLength),
    .transferDone  (transferDone),
    .linkIdle      (linkIdle)
  );

endmodule

`default_nettype wire

// File: testbench/routerOutputPort_props.sv
`include "nocRouter_consts.svh"
`default_nettype none

module routerOutputPort_props (
  input logic                      clk,
  input logic                      rst,
  input logic                      outReq,
  input logic                      outAck,
  input logic [`KIND_WIDTH-1:0]    outKind,
  input logic [`LENGTH_WIDTH-1:0]  outLength,
  input logic [`PAYLOAD_WIDTH-1:0] outPayload,
  input logic [`PORT_COUNT-1:0]    inAck
);

  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // req only falls once the sink has answered.
  reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
    $fell(outReq) |-> $past(outAck))
    else
    begin
      failCount++;
      $error("outReq fell before outAck rose");
    end

  // offered flit frozen for the whole request.
  flitStableWhileReq: assert property (@(posedge clk) disable iff (rst)
    (outReq && $past(outReq)) |-> $stable({outKind, outLength, outPayload}))
    else
    begin
      failCount++;
      $error("output flit changed while outReq was high");
    end

  oneInputAcked: assert property (@(posedge clk) disable iff (rst) $onehot0(inAck))
    else
    begin
      failCount++;
      $error("more than one input ack high");
    end

endmodule

`default_nettype wire

// File: testbench/routerOutputPort_tb.sv
`include "nocRouter_consts.svh"
`default_nettype none

module routerOutputPort_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef nocPkg::flit flitQueue [$];

  // worst case flits over all tests, margin covers reset, idle check and stall.
  localparam int flitBudget = 127;
  localparam int cycleLimit = 20 * flitBudget + 80;

  logic                      clk;
  logic                      rst;
  logic [`PORT_COUNT-1:0]    inReq;
  logic [`PORT_COUNT-1:0]    inAck;
  logic [`KIND_WIDTH-1:0]    inKind [`PORT_COUNT];
  logic [`LENGTH_WIDTH-1:0]  inLength [`PORT_COUNT];
  logic [`PAYLOAD_WIDTH-1:0] inPayload [`PORT_COUNT];
  logic                      outReq;
  logic                      outAck;
  logic [`KIND_WIDTH-1:0]    outKind;
  logic [`LENGTH_WIDTH-1:0]  outLength;
  logic [`PAYLOAD_WIDTH-1:0] outPayload;

  flitQueue    portQueue [`PORT_COUNT];
  int          gapCycles [`PORT_COUNT];
  flitQueue    expectQueue;
  flitQueue    gotQueue;
  logic        holdAck;
  int          cycleCount;
  nocPkg::flit held;

  routerOutputPort routerOutputPort_i (.*);

  bind routerOutputPort routerOutputPort_props propsCheck_i (
    .clk        (clk),
    .rst        (rst),
    .outReq     (outReq),
    .outAck     (outAck),
    .outKind    (outKind),
    .outLength  (outLength),
    .outPayload (outPayload),
    .inAck      (inAck)
  );

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      failRun($sformatf("[ERROR] %0d ns: %s got %0h expected %0h", $time, what, got, exp));
  endtask

  // header first, tail last, length only in the header.
  task automatic makePacket(input int port, input int len);
    nocPkg::flit f;
    for (int k = 0; k < len; k++)
    begin
      f.kind = (k == 0) ? nocPkg::kindHeader :
               (k == len - 1) ? nocPkg::kindTail : nocPkg::kindBody;
      f.length = (k == 0) ? `LENGTH_WIDTH'(len) : '0;
      f.payload = $urandom;
      portQueue[port].push_back(f);
    end
  endtask

  // packets in round robin from local, skipping drained ports.
  function automatic flitQueue expectedOrder(input flitQueue queues [`PORT_COUNT]);
    flitQueue result;
    int       pos [`PORT_COUNT];
    int       len;
    bit       remaining;
    pos = '{default: 0};
    remaining = 1'b1;
    while (remaining)
    begin
      remaining = 1'b0;
      for (int p = 0; p < `PORT_COUNT; p++)
      begin
        if (pos[p] < queues[p].size())
        begin
          len = int'(queues[p][pos[p]].length);
          for (int k = 0; k < len; k++)
            result.push_back(queues[p][pos[p] + k]);
          pos[p] += len;
          remaining = 1'b1;
        end
      end
    end
    return result;
  endfunction

  task automatic drivePort(input int p);
    nocPkg::flit f;
    while (portQueue[p].size() > 0)
    begin
      f = portQueue[p].pop_front();
      @(negedge clk);
      inKind[p] = f.kind;
      inLength[p] = f.length;
      inPayload[p] = f.payload;
      inReq[p] = 1'b1;
      do @(negedge clk); while (!inAck[p]);
      inReq[p] = 1'b0;
      do @(negedge clk); while (inAck[p]);
      if (f.kind != nocPkg::kindTail)
        repeat (gapCycles[p]) @(negedge clk);
    end
  endtask

  task automatic runTraffic();
    expectQueue = expectedOrder(portQueue);
    for (int p = 0; p < `PORT_COUNT; p++)
    begin
      fork
        automatic int port = p;
        drivePort(port);
      join_none
    end
    wait fork;
    while (expectQueue.size() > 0 || gotQueue.size() > 0)
      @(negedge clk);
    gapCycles = '{default: 0};
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // sink with random ack delay.
  initial
  begin
    int delay;
    forever
    begin
      @(negedge clk);
      if (outReq && !rst)
      begin
        while (holdAck)
          @(negedge clk);
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        gotQueue.push_back({outKind, outLength, outPayload});
        outAck = 1'b1;
        do @(negedge clk); while (outReq);
        outAck = 1'b0;
      end
    end
  end

  initial
  begin
    nocPkg::flit got;
    forever
    begin
      @(posedge clk);
      while (gotQueue.size() > 0)
      begin
        got = gotQueue.pop_front();
        if (expectQueue.size() == 0)
          failRun("an output flit appeared that no test expected");
        else
          checkValue("output flit", got, expectQueue.pop_front());
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
      failRun("timeout: the DUT stopped making progress");
    if (routerOutputPort_i.propsCheck_i.failCount != 0)
      failRun("a protocol assertion on the DUT failed");
  end

  initial
  begin
    void'($urandom(45));
    rst = 1'b1;
    inReq = '0;
    outAck = 1'b0;
    holdAck = 1'b0;
    cycleCount = 0;
    gapCycles = '{default: 0};
    for (int p = 0; p < `PORT_COUNT; p++)
    begin
      inKind[p] = '0;
      inLength[p] = '0;
      inPayload[p] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet after reset.
    repeat (10)
    begin
      @(negedge clk);
      checkValue("outReq after reset", outReq, 0);
      checkValue("inAck after reset", inAck, 0);
      checkValue("output flits after reset", gotQueue.size(), 0);
    end

    for (int n = 0; n < 4; n++)
      makePacket(int'(nocPkg::portNorth), $urandom_range(6, 2));
    runTraffic();

    for (int p = 0; p < `PORT_COUNT; p++)
      for (int n = 0; n < 3; n++)
        makePacket(p, $urandom_range(6, 2));
    runTraffic();

    // stalled sink must freeze both sides.
    holdAck = 1'b1;
    makePacket(int'(nocPkg::portEast), 3);
    fork
      runTraffic();
      begin
        do @(negedge clk); while (!outReq);
        held = {outKind, outLength, outPayload};
        repeat (30)
        begin
          @(negedge clk);
          checkValue("inAck during stall", inAck, 0);
          checkValue("outReq during stall", outReq, 1);
          checkValue("flit during stall", {outKind, outLength, outPayload}, held);
        end
        holdAck = 1'b0;
      end
    join

    // north drops req between flits but keeps the grant.
    gapCycles[int'(nocPkg::portNorth)] = 3;
    makePacket(int'(nocPkg::portNorth), 6);
    makePacket(int'(nocPkg::portEast), 4);
    runTraffic();

    if (routerOutputPort_i.propsCheck_i.failCount == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
      failRun("a protocol assertion on the DUT failed");
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/nocPkg.sv
design/flitLink.sv
design/flitCounter.sv
design/packetArbiter.sv
design/flitSwitch.sv
design/routerOutputPort.sv
testbench/routerOutputPort_props.sv
testbench/routerOutputPort_tb.sv
